/* lsu_consts.svh */
//////////////////////////////////////////////////////////////
// Load/store slice widths, info-field bit positions and size codes
//////////////////////////////////////////////////////////////
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Datapath and DTCM geometry
`define LSU_XLEN         32
`define LSU_DTCM_AW      10
`define LSU_ITAG_W       4

// Decode info field layout
`define LSU_INFO_W       5
`define LSU_INFO_LOAD    0
`define LSU_INFO_STORE   1
`define LSU_INFO_SIZE_LO 2
`define LSU_INFO_SIZE_HI 3
`define LSU_INFO_USIGN   4

// Access size codes carried in the info field
`define LSU_SIZE_B       2'd0
`define LSU_SIZE_H       2'd1
`define LSU_SIZE_W       2'd2

`endif

/* lsu_pkg.sv */
//////////////////////////////////////////////////////////////
// Shared types of the load/store slice
//////////////////////////////////////////////////////////////
`include "lsu_consts.svh"

package lsu_pkg;

  // Architectural data word
  typedef logic [`LSU_XLEN-1:0] xlen_t;

  // DTCM byte address, upper bits of the sum are dropped
  typedef logic [`LSU_DTCM_AW-1:0] dtcm_addr_t;

  // Word index into the DTCM array
  typedef logic [`LSU_DTCM_AW-3:0] dtcm_widx_t;

  // One bit per byte lane
  typedef logic [`LSU_XLEN/8-1:0] wmask_t;

  // Instruction tag echoed on write-back
  typedef logic [`LSU_ITAG_W-1:0] itag_t;

  // Decode info, {usign, size[1:0], store, load}
  typedef logic [`LSU_INFO_W-1:0] agu_info_t;

  // Byte, half, word, or the illegal code 3
  typedef logic [1:0] lsu_size_t;

  // One-slot response holder
  typedef enum logic {
    RSP_IDLE = 1'b0,
    RSP_FULL = 1'b1
  } rsp_state_t;

endpackage

/* lsu_cmd_if.sv */
//////////////////////////////////////////////////////////////
// Command bundle from the AGU to the DTCM and response stage
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface lsu_cmd_if import lsu_pkg::*; ();

  // Accepted operation this cycle
  logic       fire;
  // Memory strobes, only for aligned accesses
  logic       ram_wen;
  logic       ram_ren;
  dtcm_addr_t addr;
  wmask_t     wmask;
  xlen_t      wdata;
  // Per-operation info for the response stage
  lsu_size_t  size;
  logic       usign;
  itag_t      itag;
  logic       is_mem;
  logic       misalgn;
  // Slot free, driven back by the response stage
  logic       ready;

  modport agu (
    output fire, ram_wen, ram_ren, addr, wmask, wdata,
    output size, usign, itag, is_mem, misalgn,
    input  ready
  );

  modport ram (
    input ram_wen, ram_ren, addr, wmask, wdata
  );

  modport rsp (
    input  fire, ram_ren, addr, size, usign, itag, is_mem, misalgn,
    output ready
  );

endinterface

/* exu_alu_lsuagu.sv */
//////////////////////////////////////////////////////////////
// Load/store AGU with address add, alignment check,
// store lane replication, byte mask and command drive
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_consts.svh"

module exu_alu_lsuagu import lsu_pkg::*; (
  input  logic      i_valid,
  output logic      i_ready,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  agu_info_t i_info,
  input  itag_t     i_itag,
  lsu_cmd_if.agu    cmd
);

  logic       agu_load;
  logic       agu_store;
  lsu_size_t  agu_size;
  logic       agu_usign;
  logic       size_b;
  logic       size_h;
  logic       size_w;
  logic       size_bad;
  xlen_t      agu_sum;
  dtcm_addr_t agu_addr;
  logic       agu_is_mem;
  logic       agu_misalgn;
  logic       agu_fire;
  xlen_t      st_wdata;
  wmask_t     st_wmask;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  assign agu_load  = i_info[`LSU_INFO_LOAD];
  assign agu_store = i_info[`LSU_INFO_STORE];
  assign agu_size  = i_info[`LSU_INFO_SIZE_HI:`LSU_INFO_SIZE_LO];
  assign agu_usign = i_info[`LSU_INFO_USIGN];

  assign size_b   = (agu_size == `LSU_SIZE_B);
  assign size_h   = (agu_size == `LSU_SIZE_H);
  assign size_w   = (agu_size == `LSU_SIZE_W);
  assign size_bad = ~(size_b | size_h | size_w);

  ////////////////////////////////////////////////////////////
  // Address and alignment
  ////////////////////////////////////////////////////////////
  // Full add, then keep only the DTCM byte address
  assign agu_sum  = i_rs1 + i_imm;
  assign agu_addr = agu_sum[`LSU_DTCM_AW-1:0];

  assign agu_is_mem = agu_load | agu_store;

  // Only memory ops can be misaligned; address-only ops never error
  assign agu_misalgn = agu_is_mem & ( size_bad
                                    | (size_h & agu_addr[0])
                                    | (size_w & (agu_addr[1:0] != 2'b00)));

  // Handshake passes straight through to the response slot
  assign i_ready  = cmd.ready;
  assign agu_fire = i_valid & cmd.ready;

  ////////////////////////////////////////////////////////////
  // Store data and byte mask
  ////////////////////////////////////////////////////////////
  // Replicate the low lane(s) so every byte position carries the data
  assign st_wdata = ({`LSU_XLEN{size_b}} & {4{i_rs2[7:0]}})
                  | ({`LSU_XLEN{size_h}} & {2{i_rs2[15:0]}})
                  | ({`LSU_XLEN{size_w}} & i_rs2);

  // Mask shifted to the addressed lane
  assign st_wmask = ({(`LSU_XLEN/8){size_b}} & (4'b0001 << agu_addr[1:0]))
                  | ({(`LSU_XLEN/8){size_h}} & (4'b0011 << {agu_addr[1], 1'b0}))
                  | ({(`LSU_XLEN/8){size_w}} & 4'b1111);

  ////////////////////////////////////////////////////////////
  // Command drive
  ////////////////////////////////////////////////////////////
  assign cmd.fire    = agu_fire;
  // Strobes suppressed for misaligned or illegal-size ops
  assign cmd.ram_wen = agu_fire & agu_store & ~agu_misalgn;
  assign cmd.ram_ren = agu_fire & agu_load & ~agu_misalgn;
  assign cmd.addr    = agu_addr;
  assign cmd.wmask   = st_wmask;
  assign cmd.wdata   = st_wdata;
  assign cmd.size    = agu_size;
  assign cmd.usign   = agu_usign;
  assign cmd.itag    = i_itag;
  assign cmd.is_mem  = agu_is_mem;
  assign cmd.misalgn = agu_misalgn;

  // Decoder upstream must never mark an op as both load and store
  always_comb begin
    if (i_valid) begin
      a_ld_st_excl: assert final (!(agu_load && agu_store))
        else $error("AGU got load and store together");
    end
  end

endmodule

/* lsu_dtcm_ram.sv */
//////////////////////////////////////////////////////////////
// DTCM array, byte-masked write, registered read
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_dtcm_ram import lsu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  lsu_cmd_if.ram cmd,
  output xlen_t  rdata
);

  localparam int unsigned DEPTH = 1 << (`LSU_DTCM_AW - 2);

  xlen_t      mem [DEPTH];
  dtcm_widx_t widx;

  // Word index, byte offset bits dropped
  assign widx = cmd.addr[`LSU_DTCM_AW-1:2];

  // Write only the lanes selected by the mask
  always_ff @(posedge clk) begin
    if (cmd.ram_wen) begin
      for (int b = 0; b < `LSU_XLEN/8; b++) begin
        if (cmd.wmask[b]) begin
          mem[widx][8*b +: 8] <= cmd.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data held until the next read, so it stays valid
  // while the response stage waits on back-pressure
  always_ff @(posedge clk) begin
    if (cmd.ram_ren) begin
      rdata <= mem[widx];
    end
  end

  // One op per cycle, so read and write strobes are exclusive
  a_rw_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cmd.ram_wen && cmd.ram_ren)
  ) else $error("DTCM read and write strobed together");

endmodule

/* lsu_rsp_ctrl.sv */
//////////////////////////////////////////////////////////////
// One-slot response stage with load alignment and extension,
// error flag and output back-pressure
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_rsp_ctrl import lsu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  lsu_cmd_if.rsp cmd,
  input  xlen_t  rdata,
  output logic   o_valid,
  output xlen_t  o_wdat,
  output logic   o_err,
  output itag_t  o_itag,
  input  logic   o_ready
);

  rsp_state_t state_r;
  rsp_state_t state_nxt;

  // Captured per-operation info
  itag_t      rsp_itag;
  lsu_size_t  rsp_size;
  logic       rsp_usign;
  logic       rsp_load;
  logic       rsp_mem;
  logic       rsp_err;
  dtcm_addr_t rsp_addr;

  xlen_t      ld_shift;
  xlen_t      ld_data;

  ////////////////////////////////////////////////////////////
  // Slot control
  ////////////////////////////////////////////////////////////
  // Accept when empty or when the held response leaves this cycle
  assign cmd.ready = (state_r == RSP_IDLE) | o_ready;

  always_comb begin
    state_nxt = state_r;
    if (cmd.fire) begin
      state_nxt = RSP_FULL;
    end else if (o_ready) begin
      state_nxt = RSP_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r <= RSP_IDLE;
    end else begin
      state_r <= state_nxt;
    end
  end

  // Payload capture on acceptance
  always_ff @(posedge clk) begin
    if (cmd.fire) begin
      rsp_itag  <= cmd.itag;
      rsp_size  <= cmd.size;
      rsp_usign <= cmd.usign;
      rsp_load  <= cmd.ram_ren;
      rsp_mem   <= cmd.is_mem;
      rsp_err   <= cmd.misalgn;
      rsp_addr  <= cmd.addr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Load alignment and extension
  ////////////////////////////////////////////////////////////
  // Bring the addressed lane down to bit 0
  assign ld_shift = rdata >> {rsp_addr[1:0], 3'b000};

  always_comb begin
    case (rsp_size)
      `LSU_SIZE_B: ld_data = {{(`LSU_XLEN-8){~rsp_usign & ld_shift[7]}}, ld_shift[7:0]};
      `LSU_SIZE_H: ld_data = {{(`LSU_XLEN-16){~rsp_usign & ld_shift[15]}}, ld_shift[15:0]};
      default:     ld_data = rdata;
    endcase
  end

  // Write-back select; stores and errors return zero
  always_comb begin
    if (rsp_err) begin
      o_wdat = '0;
    end else if (rsp_load) begin
      o_wdat = ld_data;
    end else if (rsp_mem) begin
      o_wdat = '0;
    end else begin
      // address-only op, return the wrapped DTCM address
      o_wdat = {{(`LSU_XLEN-`LSU_DTCM_AW){1'b0}}, rsp_addr};
    end
  end

  assign o_valid = (state_r == RSP_FULL);
  assign o_err   = rsp_err;
  assign o_itag  = rsp_itag;

  // Held response must not change while stalled; also relies on the
  // DTCM keeping its read register until the next accepted load
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (o_valid && !o_ready) |=> (o_valid && $stable(o_wdat))
  ) else $error("Response changed under back-pressure");

endmodule

/* exu_lsu_top.sv */
//////////////////////////////////////////////////////////////
// Load/store slice top, AGU plus DTCM plus response stage
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exu_lsu_top import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Operation request
  input  logic      i_valid,
  output logic      i_ready,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  agu_info_t i_info,
  input  itag_t     i_itag,

  // Write-back
  output logic      o_valid,
  input  logic      o_ready,
  output xlen_t     o_wdat,
  output logic      o_err,
  output itag_t     o_itag
);

  // Command fan-out shared by RAM and response stage
  lsu_cmd_if u_cmd ();

  // Registered DTCM word into the response stage
  xlen_t ram_rdata;

  exu_alu_lsuagu u_agu (
    .i_valid (i_valid),
    .i_ready (i_ready),
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .i_imm   (i_imm),
    .i_info  (i_info),
    .i_itag  (i_itag),
    .cmd     (u_cmd.agu)
  );

  lsu_dtcm_ram u_dtcm (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (u_cmd.ram),
    .rdata (ram_rdata)
  );

  lsu_rsp_ctrl u_rsp (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (u_cmd.rsp),
    .rdata   (ram_rdata),
    .o_valid (o_valid),
    .o_wdat  (o_wdat),
    .o_err   (o_err),
    .o_itag  (o_itag),
    .o_ready (o_ready)
  );

endmodule

/* tb_lsu_checker.sv */
//////////////////////////////////////////////////////////////
// Response checker with byte-level DTCM model, reference
// function, in-order compare and error counting
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu_checker import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_valid,
  input  logic      i_ready,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  agu_info_t i_info,
  input  itag_t     i_itag,
  input  logic      o_valid,
  input  logic      o_ready,
  input  xlen_t     o_wdat,
  input  logic      o_err,
  input  itag_t     o_itag,
  output int        err_count,
  output int        acc_count,
  output int        rsp_count,
  output int        pending
);

  // 1 KB byte image of the DTCM
  logic [7:0]  model [1024];
  // Expected {wdat, err, itag} with the oldest first
  logic [36:0] exp_q [$];
  logic [36:0] head;
  // Previous-edge state for timing and hold checks
  logic        fired_d;
  logic        stall_d;
  xlen_t       wdat_d;
  logic        err_d;
  itag_t       itag_d;

  initial begin
    err_count = 0;
    acc_count = 0;
    rsp_count = 0;
    pending   = 0;
    fired_d   = 1'b0;
    stall_d   = 1'b0;
    wdat_d    = '0;
    err_d     = 1'b0;
    itag_d    = '0;
    for (int a = 0; a < 1024; a++) begin
      model[a] = 8'h00;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [36:0] ref_result(xlen_t rs1, xlen_t rs2, xlen_t imm,
                                              agu_info_t info, itag_t itag);
    int unsigned addr;
    int unsigned nbytes;
    logic        ld;
    logic        st;
    logic [1:0]  sz;
    logic        bad;
    xlen_t       val;
    addr   = (rs1 + imm) % 1024;
    ld     = info[`LSU_INFO_LOAD];
    st     = info[`LSU_INFO_STORE];
    sz     = info[`LSU_INFO_SIZE_HI:`LSU_INFO_SIZE_LO];
    nbytes = 1 << sz;
    // Memory ops need natural alignment and a legal size
    bad    = (ld || st) && ((sz == 2'd3) || ((addr % nbytes) != 0));
    val    = '0;
    if (bad) begin
      return {32'h0, 1'b1, itag};
    end
    if (st) begin
      for (int k = 0; k < nbytes; k++) begin
        model[addr + k] = rs2[8*k +: 8];
      end
    end else if (ld) begin
      // Little-endian gather
      for (int k = 0; k < nbytes; k++) begin
        val[8*k +: 8] = model[addr + k];
      end
      if (!info[`LSU_INFO_USIGN] && val[8*nbytes-1]) begin
        val = val | ~((32'h1 << (8*nbytes)) - 32'h1);
      end
    end else begin
      val = addr;
    end
    return {val, 1'b0, itag};
  endfunction

  task automatic check_field(input string name, input xlen_t act, input xlen_t exp);
    if (act !== exp) begin
      $display("ERR %s act=0x%0h exp=0x%0h", name, act, exp);
      err_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Port monitor
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      // Slot is free when nothing is outstanding or the held response leaves now
      check_field("i_ready", i_ready, (exp_q.size() == 0) || o_ready);
      // Held response must not move until it transfers
      if (stall_d) begin
        check_field("o_valid under back-pressure", o_valid, 1'b1);
        check_field("o_wdat under back-pressure", o_wdat, wdat_d);
        check_field("o_err under back-pressure", o_err, err_d);
        check_field("o_itag under back-pressure", o_itag, itag_d);
      end
      // Response transfers at this edge
      if (o_valid && o_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error: response with tag %h arrived with nothing outstanding", o_itag);
          err_count++;
        end else begin
          head = exp_q.pop_front();
          check_field("o_wdat", o_wdat, head[36:5]);
          check_field("o_err", o_err, head[4]);
          check_field("o_itag", o_itag, head[3:0]);
        end
        rsp_count++;
      end
      // Every accepted op shows up one cycle later
      if (fired_d && !o_valid) begin
        $display("Error: o_valid did not rise one cycle after an accepted operation");
        err_count++;
      end
      if (i_valid && i_ready) begin
        exp_q.push_back(ref_result(i_rs1, i_rs2, i_imm, i_info, i_itag));
        acc_count++;
      end
      fired_d = i_valid && i_ready;
      stall_d = o_valid && !o_ready;
      wdat_d  = o_wdat;
      err_d   = o_err;
      itag_d  = o_itag;
      pending = exp_q.size();
    end
  end

endmodule

/* tb_exu_lsu_top.sv */
//////////////////////////////////////////////////////////////
// Testbench top for the load/store slice, clock, reset,
// LCG, stimulus tasks, test sequence and summary
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_exu_lsu_top import lsu_pkg::*; ();

  localparam int TMO = 200;

  logic        clk;
  logic        rst_n;
  logic        i_valid;
  logic        i_ready;
  xlen_t       i_rs1;
  xlen_t       i_rs2;
  xlen_t       i_imm;
  agu_info_t   i_info;
  itag_t       i_itag;
  logic        o_valid;
  logic        o_ready;
  xlen_t       o_wdat;
  logic        o_err;
  itag_t       o_itag;

  // Checker counters
  int          err_count;
  int          acc_count;
  int          rsp_count;
  int          pending;

  int unsigned stim_seed;
  int unsigned bp_seed;
  int unsigned bp_rand;
  logic        bp_on;
  itag_t       tag_ctr;
  int          fail_count;
  int          test_base;

  exu_lsu_top dut (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_valid), .i_ready(i_ready), .i_rs1(i_rs1), .i_rs2(i_rs2),
    .i_imm(i_imm), .i_info(i_info), .i_itag(i_itag),
    .o_valid(o_valid), .o_ready(o_ready), .o_wdat(o_wdat), .o_err(o_err), .o_itag(o_itag)
  );

  tb_lsu_checker u_chk (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_valid), .i_ready(i_ready), .i_rs1(i_rs1), .i_rs2(i_rs2),
    .i_imm(i_imm), .i_info(i_info), .i_itag(i_itag),
    .o_valid(o_valid), .o_ready(o_ready), .o_wdat(o_wdat), .o_err(o_err), .o_itag(o_itag),
    .err_count(err_count), .acc_count(acc_count), .rsp_count(rsp_count), .pending(pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic int unsigned lcg_next(inout int unsigned state);
    state = state * 32'd1103515245 + 32'd12345;
    return state;
  endfunction

  function automatic agu_info_t mk_info(logic ld, logic st, lsu_size_t size, logic usign);
    agu_info_t info;
    info = '0;
    info[`LSU_INFO_LOAD] = ld;
    info[`LSU_INFO_STORE] = st;
    info[`LSU_INFO_SIZE_HI:`LSU_INFO_SIZE_LO] = size;
    info[`LSU_INFO_USIGN] = usign;
    return info;
  endfunction

  // Output back-pressure at 75% ready when enabled
  always @(posedge clk) begin
    bp_rand = lcg_next(bp_seed);
    o_ready <= bp_on ? (bp_rand[17] | bp_rand[9]) : 1'b1;
  end

  // Called at a rising edge and returns at the accepting edge
  task automatic send_op(input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                         input agu_info_t info);
    int waited;
    i_valid <= 1'b1;
    i_rs1   <= rs1;
    i_rs2   <= rs2;
    i_imm   <= imm;
    i_info  <= info;
    i_itag  <= tag_ctr;
    waited  = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!i_ready && waited < TMO);
    if (!i_ready) begin
      $display("Timeout: operation with tag %h was never accepted", tag_ctr);
      fail_count++;
    end
    tag_ctr++;
    i_valid <= 1'b0;
  endtask

  // Negative immediate so the adder really sums
  task automatic store_op(input xlen_t addr, input xlen_t data, input lsu_size_t size);
    send_op(addr + 32'd16, data, 32'hFFFF_FFF0, mk_info(1'b0, 1'b1, size, 1'b0));
  endtask

  task automatic load_op(input xlen_t addr, input lsu_size_t size, input logic usign);
    send_op(addr + 32'd16, 32'h5A5A_5A5A, 32'hFFFF_FFF0, mk_info(1'b1, 1'b0, size, usign));
  endtask

  // Drain outstanding responses and report the test
  task automatic end_test(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (pending != 0 && waited < TMO) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d responses still outstanding after test %s", pending, name);
      fail_count++;
    end
    $display("test %-8s %s, %0d errors", name,
             (err_count + fail_count == test_base) ? "passed" : "failed",
             err_count + fail_count - test_base);
    test_base = err_count + fail_count;
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int unsigned r;
    int unsigned a;
    xlen_t       imm;
    lsu_size_t   sz;
    logic [2:0]  k;
    logic [7:0]  bv;
    rst_n      = 1'b0;
    i_valid    = 1'b0;
    i_rs1      = '0;
    i_rs2      = '0;
    i_imm      = '0;
    i_info     = '0;
    i_itag     = '0;
    o_ready    = 1'b1;
    stim_seed  = 6;
    bp_seed    = 6;
    bp_on      = 1'b0;
    tag_ctr    = '0;
    fail_count = 0;
    test_base  = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Known contents everywhere from a pattern over the whole word index
    for (int w = 0; w < 256; w++) begin
      bv = w;
      store_op(w * 4, {bv ^ 8'hA5, ~bv, bv, bv + 8'h3C}, `LSU_SIZE_W);
    end
    end_test("fill");

    store_op(32'h120, 32'hDEAD_BEEF, `LSU_SIZE_W);
    load_op(32'h120, `LSU_SIZE_W, 1'b0);
    store_op(32'h3FC, 32'h1357_9BDF, `LSU_SIZE_W);
    load_op(32'h3FC, `LSU_SIZE_W, 1'b1);
    end_test("word");

    // Bytes of both signs in each lane with junk in upper rs2 bits
    for (int b = 0; b < 4; b++) begin
      bv = 8'h7E + 8'h11 * b;
      store_op(32'h40 + b, {24'hABCDEF, bv}, `LSU_SIZE_B);
    end
    for (int b = 0; b < 4; b++) begin
      load_op(32'h40 + b, `LSU_SIZE_B, 1'b0);
      load_op(32'h40 + b, `LSU_SIZE_B, 1'b1);
    end
    store_op(32'h4A, 32'hFFFF_8001, `LSU_SIZE_H);
    store_op(32'h4C, 32'h0000_7FF0, `LSU_SIZE_H);
    load_op(32'h48, `LSU_SIZE_W, 1'b0);
    load_op(32'h4C, `LSU_SIZE_W, 1'b0);
    for (int h = 0; h < 4; h++) begin
      load_op(32'h48 + 2 * h, `LSU_SIZE_H, 1'b0);
      load_op(32'h48 + 2 * h, `LSU_SIZE_H, 1'b1);
    end
    end_test("lanes");

    load_op(32'h61, `LSU_SIZE_H, 1'b0);
    load_op(32'h62, `LSU_SIZE_W, 1'b0);
    store_op(32'h63, 32'hFFFF_FFFF, `LSU_SIZE_W);
    store_op(32'h65, 32'hFFFF_FFFF, `LSU_SIZE_H);
    store_op(32'h60, 32'hFFFF_FFFF, 2'd3);
    load_op(32'h64, 2'd3, 1'b1);
    load_op(32'h60, `LSU_SIZE_W, 1'b0);
    load_op(32'h64, `LSU_SIZE_W, 1'b0);
    end_test("misalign");

    // Address-only ops where several wrap past 1 KB or 4 GB
    send_op(32'h0000_0100, 32'h0, 32'h0000_0024, mk_info(1'b0, 1'b0, `LSU_SIZE_W, 1'b0));
    send_op(32'h0000_03F8, 32'h0, 32'h0000_0010, mk_info(1'b0, 1'b0, `LSU_SIZE_B, 1'b0));
    send_op(32'hFFFF_FFFC, 32'h0, 32'h0000_0008, mk_info(1'b0, 1'b0, `LSU_SIZE_H, 1'b1));
    send_op(32'h1234_5678, 32'h0, 32'h0000_0000, mk_info(1'b0, 1'b0, 2'd3, 1'b1));
    send_op(32'h0000_0000, 32'h0, 32'hFFFF_FFFF, mk_info(1'b0, 1'b0, `LSU_SIZE_W, 1'b0));
    end_test("addr");

    bp_on <= 1'b1;
    for (int n = 0; n < 200; n++) begin
      r   = lcg_next(stim_seed);
      sz  = (r[7:4] == 4'hF) ? 2'd3 : r[3:2] % 3;
      a   = lcg_next(stim_seed) % 1024;
      // Mostly aligned with one in eight left as drawn
      if (r[10:8] != 3'd0) begin
        a = a & ~((32'd1 << sz) - 32'd1);
      end
      imm = lcg_next(stim_seed);
      k   = r[13:11];
      send_op(a - imm, lcg_next(stim_seed), imm,
              mk_info((k < 3) || (k == 6), (k >= 3) && (k < 6), sz, r[14]));
      if (r[17:15] == 3'd0) begin
        @(posedge clk);
      end
    end
    end_test("random");
    bp_on <= 1'b0;

    if (acc_count != rsp_count) begin
      $display("Error: %0d operations accepted but %0d responses seen", acc_count, rsp_count);
      fail_count++;
    end
    $display("summary: %0d operations, %0d responses, %0d compare errors, %0d other failures",
             acc_count, rsp_count, err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* exu_lsu_top.f */
+incdir+.
lsu_pkg.sv
lsu_cmd_if.sv
exu_alu_lsuagu.sv
lsu_dtcm_ram.sv
lsu_rsp_ctrl.sv
exu_lsu_top.sv
tb_lsu_checker.sv
tb_exu_lsu_top.sv
